/* hw/rs_pkg.sv */
// Shared types for the dispatch and reservation station slice
// Tags are reorder-buffer indices and every op carries exactly two sources
package rs_pkg;

    localparam int DATA_WIDTH = 32;
    localparam int TAG_WIDTH  = 5;
    localparam int SRC_COUNT  = 2;

    // Op class as produced by decode
    typedef enum logic [1:0] {
        RS_OP_ALU    = 2'd0,
        RS_OP_BRANCH = 2'd1,
        RS_OP_LOAD   = 2'd2,
        RS_OP_STORE  = 2'd3
    } rs_op_e;

    // Functional unit that a station feeds
    typedef enum logic {
        RS_FU_IEU = 1'b0,
        RS_FU_LSU = 1'b1
    } rs_fu_e;

    // Data is only meaningful once rdy is set, until then tag names the producer
    typedef struct packed {
        logic                  rdy;
        logic [TAG_WIDTH-1:0]  tag;
        logic [DATA_WIDTH-1:0] data;
    } rs_src_t;

    typedef struct packed {
        rs_op_e                      op;
        logic [TAG_WIDTH-1:0]        dst_tag;
        rs_src_t [SRC_COUNT-1:0]     src;
    } rs_op_t;

    // One result broadcast on the common data bus
    typedef struct packed {
        logic                  en;
        logic [TAG_WIDTH-1:0]  tag;
        logic [DATA_WIDTH-1:0] data;
    } rs_cdb_t;

    // Issue payload, sources are always resolved by now so only data is sent
    typedef struct packed {
        rs_op_e                                op;
        logic [TAG_WIDTH-1:0]                  dst_tag;
        logic [SRC_COUNT-1:0][DATA_WIDTH-1:0]  src_data;
    } rs_issue_t;

endpackage

/* hw/rs_rr_picker.sv */
// Round-robin picker with a rotating start pointer
// The pointer moves only when i_valid is high and a request was granted
`timescale 1ns/10ps

module rs_rr_picker #(
    parameter int OPTN_WIDTH = 3
)(
    input  logic                  clk,
    input  logic                  i_arst_n,
    input  logic                  i_valid,
    input  logic [OPTN_WIDTH-1:0] i_requests,
    output logic [OPTN_WIDTH-1:0] o_grant
);

    localparam int PTR_WIDTH = (OPTN_WIDTH > 1) ? $clog2(OPTN_WIDTH) : 1;

    logic [PTR_WIDTH-1:0] r_ptr;
    logic [PTR_WIDTH-1:0] grant_idx;
    logic                 grant_found;

    // Search starts at the pointer and wraps, so every request is seen once
    always_comb begin
        int idx;
        o_grant     = '0;
        grant_idx   = '0;
        grant_found = 1'b0;
        for (int i = 0; i < OPTN_WIDTH; i++) begin
            idx = (int'(r_ptr) + i) % OPTN_WIDTH;
            if (!grant_found && i_requests[idx]) begin
                grant_found = 1'b1;
                grant_idx   = PTR_WIDTH'(idx);
            end
        end
        if (grant_found) begin
            o_grant[grant_idx] = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            r_ptr <= '0;
        end else if (i_valid && grant_found) begin
            r_ptr <= (grant_idx == PTR_WIDTH'(OPTN_WIDTH - 1)) ? '0 : grant_idx + 1'b1;
        end
    end

    assert property (@(posedge clk) disable iff (!i_arst_n)
        $onehot0(o_grant) && ((o_grant & ~i_requests) == '0))
        else $error("rr picker granted an unrequested or multiple bits");

endmodule

/* hw/rs_dispatch_stage.sv */
// Single pipeline register between the front end and the station switch
// No skid buffer, so the source must hold its op while o_disp_stall is high
`timescale 1ns/10ps

module rs_dispatch_stage
    import rs_pkg::*;
(
    input  logic   clk,
    input  logic   i_arst_n,

    input  logic   i_disp_valid,
    input  rs_op_t i_disp_op,
    output logic   o_disp_stall,

    input  logic   i_stall,
    output logic   o_valid,
    output rs_op_t o_op
);

    logic   r_valid;
    rs_op_t r_op;
    logic   load_en;

    // An empty register can always take a new op, a full one only when the switch moves it on
    assign load_en = !r_valid || !i_stall;

    // The stall only matters while an op is actually held
    assign o_disp_stall = r_valid && i_stall;

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            r_valid <= 1'b0;
        end else if (load_en) begin
            r_valid <= i_disp_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (load_en) begin
            r_op <= i_disp_op;
        end
    end

    assign o_valid = r_valid;
    assign o_op    = r_op;

    // A stalled op must reach the switch again unchanged on the next cycle
    assert property (@(posedge clk) disable iff (!i_arst_n)
        (o_valid && i_stall) |=> (o_valid && $stable(o_op)))
        else $error("dispatch register changed while stalled");

endmodule

/* hw/rs_switch.sv */
// Routes the dispatched op to one station of the right unit type
// Same-cycle CDB results are bypassed into sources that are still waiting
// OPTN_RS_FU_MASK must mark at least one station of each type that is used
`timescale 1ns/10ps

module rs_switch
    import rs_pkg::*;
#(
    parameter int                       OPTN_RS_COUNT   = 3,
    parameter int                       OPTN_CDB_DEPTH  = 2,
    parameter logic [OPTN_RS_COUNT-1:0] OPTN_RS_FU_MASK = 3'b100
)(
    input  logic                     clk,
    input  logic                     i_arst_n,

    input  logic                     i_valid,
    input  rs_op_t                   i_op,

    input  rs_cdb_t                  i_cdb [0:OPTN_CDB_DEPTH-1],

    input  logic [OPTN_RS_COUNT-1:0] i_rs_full,
    output logic [OPTN_RS_COUNT-1:0] o_reserve_en,
    output rs_op_t                   o_op,
    output logic                     o_stall
);

    rs_fu_e                   fu_type;
    logic [OPTN_RS_COUNT-1:0] rs_supported;
    logic [OPTN_RS_COUNT-1:0] rs_granted;

    // Memory ops go to the LSU, everything else runs on the integer unit
    assign fu_type = ((i_op.op == RS_OP_LOAD) || (i_op.op == RS_OP_STORE)) ? RS_FU_LSU
                                                                          : RS_FU_IEU;

    // A set mask bit marks an LSU station
    assign rs_supported = (fu_type == RS_FU_LSU) ? OPTN_RS_FU_MASK : ~OPTN_RS_FU_MASK;

    // The picker also advances on a stall, so the retry tries the next station of that type
    rs_rr_picker #(
        .OPTN_WIDTH (OPTN_RS_COUNT)
    ) u_rs_rr_picker (
        .clk        (clk),
        .i_arst_n   (i_arst_n),
        .i_valid    (i_valid),
        .i_requests (rs_supported),
        .o_grant    (rs_granted)
    );

    assign o_reserve_en = i_valid ? (rs_granted & ~i_rs_full) : '0;
    assign o_stall      = i_valid && |(rs_granted & i_rs_full);

    // Only sources that are not ready yet look at the CDB
    always_comb begin
        o_op = i_op;
        for (int s = 0; s < SRC_COUNT; s++) begin
            for (int c = 0; c < OPTN_CDB_DEPTH; c++) begin
                if (!i_op.src[s].rdy && i_cdb[c].en && (i_cdb[c].tag == i_op.src[s].tag)) begin
                    o_op.src[s].rdy  = 1'b1;
                    o_op.src[s].data = i_cdb[c].data;
                end
            end
        end
    end

endmodule

/* hw/rs_station.sv */
// One reservation station, fills the lowest free entry and offers the lowest ready one
// An offered op is held until i_issue_ready takes it, even if a lower entry wakes up
// The caller must not assert i_reserve_en while o_full is high
`timescale 1ns/10ps

module rs_station
    import rs_pkg::*;
#(
    parameter int OPTN_RS_DEPTH  = 4,
    parameter int OPTN_CDB_DEPTH = 2
)(
    input  logic      clk,
    input  logic      i_arst_n,

    input  logic      i_reserve_en,
    input  rs_op_t    i_op,

    input  rs_cdb_t   i_cdb [0:OPTN_CDB_DEPTH-1],

    output logic      o_full,
    output logic      o_issue_valid,
    output rs_issue_t o_issue,
    input  logic      i_issue_ready
);

    localparam int IDX_WIDTH = (OPTN_RS_DEPTH > 1) ? $clog2(OPTN_RS_DEPTH) : 1;

    logic   [OPTN_RS_DEPTH-1:0] r_valid;
    rs_op_t                     r_entry [0:OPTN_RS_DEPTH-1];
    rs_op_t                     entry_wake [0:OPTN_RS_DEPTH-1];
    logic   [OPTN_RS_DEPTH-1:0] entry_ready;
    logic   [OPTN_RS_DEPTH-1:0] free_oh;
    logic   [OPTN_RS_DEPTH-1:0] take_oh;
    logic   [IDX_WIDTH-1:0]     sel_idx;
    logic                       sel_found;
    logic                       issue_take;
    logic                       r_hold;
    logic   [IDX_WIDTH-1:0]     r_hold_idx;

    assign o_full = &r_valid;

    // Lowest clear bit of the valid vector, zero when the station is full
    assign free_oh = ~r_valid & (r_valid + 1'b1);

    // Every waiting source of every entry snoops all CDB ports
    always_comb begin
        for (int e = 0; e < OPTN_RS_DEPTH; e++) begin
            entry_wake[e] = r_entry[e];
            for (int s = 0; s < SRC_COUNT; s++) begin
                for (int c = 0; c < OPTN_CDB_DEPTH; c++) begin
                    if (!r_entry[e].src[s].rdy && i_cdb[c].en &&
                        (i_cdb[c].tag == r_entry[e].src[s].tag)) begin
                        entry_wake[e].src[s].rdy  = 1'b1;
                        entry_wake[e].src[s].data = i_cdb[c].data;
                    end
                end
            end
        end
    end

    always_comb begin
        for (int e = 0; e < OPTN_RS_DEPTH; e++) begin
            entry_ready[e] = r_valid[e] && r_entry[e].src[0].rdy && r_entry[e].src[1].rdy;
        end
    end

    // Scan downwards so the lowest ready index wins, a held offer overrides the scan
    always_comb begin
        sel_idx   = '0;
        sel_found = 1'b0;
        for (int e = OPTN_RS_DEPTH - 1; e >= 0; e--) begin
            if (entry_ready[e]) begin
                sel_idx   = IDX_WIDTH'(e);
                sel_found = 1'b1;
            end
        end
        if (r_hold) begin
            sel_idx   = r_hold_idx;
            sel_found = 1'b1;
        end
    end

    assign o_issue_valid = sel_found;
    assign issue_take    = sel_found && i_issue_ready;
    assign take_oh       = issue_take ? (OPTN_RS_DEPTH'(1) << sel_idx) : '0;

    always_comb begin
        o_issue.op      = r_entry[sel_idx].op;
        o_issue.dst_tag = r_entry[sel_idx].dst_tag;
        for (int s = 0; s < SRC_COUNT; s++) begin
            o_issue.src_data[s] = r_entry[sel_idx].src[s].data;
        end
    end

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            r_valid    <= '0;
            r_hold     <= 1'b0;
            r_hold_idx <= '0;
        end else begin
            r_valid    <= (r_valid & ~take_oh) | (i_reserve_en ? free_oh : '0);
            r_hold     <= sel_found && !i_issue_ready;
            r_hold_idx <= sel_idx;
        end
    end

    // Entry payload, a new op overwrites the free slot, all others take their wakeup
    always_ff @(posedge clk) begin
        for (int e = 0; e < OPTN_RS_DEPTH; e++) begin
            if (i_reserve_en && free_oh[e]) begin
                r_entry[e] <= i_op;
            end else begin
                r_entry[e] <= entry_wake[e];
            end
        end
    end

    // The switch is the only place that checks fullness
    assert property (@(posedge clk) disable iff (!i_arst_n)
        i_reserve_en |-> !o_full)
        else $error("reserve enable while station is full");

    assert property (@(posedge clk) disable iff (!i_arst_n)
        (o_issue_valid && !i_issue_ready) |=> (o_issue_valid && $stable(o_issue)))
        else $error("issue payload changed before it was taken");

endmodule

/* hw/rs_dispatch_top.sv */
// Dispatch stage, station switch and an array of reservation stations
// OPTN_RS_FU_MASK has one bit per station, set for an LSU station
`timescale 1ns/10ps

module rs_dispatch_top
    import rs_pkg::*;
#(
    parameter int                       OPTN_RS_COUNT   = 3,
    parameter int                       OPTN_RS_DEPTH   = 4,
    parameter int                       OPTN_CDB_DEPTH  = 2,
    parameter logic [OPTN_RS_COUNT-1:0] OPTN_RS_FU_MASK = 3'b100
)(
    input  logic                     clk,
    input  logic                     i_arst_n,

    input  logic                     i_disp_valid,
    input  rs_op_t                   i_disp_op,
    output logic                     o_disp_stall,

    input  rs_cdb_t                  i_cdb [0:OPTN_CDB_DEPTH-1],

    output logic [OPTN_RS_COUNT-1:0] o_issue_valid,
    output rs_issue_t                o_issue [0:OPTN_RS_COUNT-1],
    input  logic [OPTN_RS_COUNT-1:0] i_issue_ready
);

    logic                     disp_valid;
    rs_op_t                   disp_op;
    logic                     switch_stall;
    logic [OPTN_RS_COUNT-1:0] rs_reserve_en;
    logic [OPTN_RS_COUNT-1:0] rs_full;
    rs_op_t                   rs_op;

    rs_dispatch_stage u_rs_dispatch_stage (
        .clk          (clk),
        .i_arst_n     (i_arst_n),
        .i_disp_valid (i_disp_valid),
        .i_disp_op    (i_disp_op),
        .o_disp_stall (o_disp_stall),
        .i_stall      (switch_stall),
        .o_valid      (disp_valid),
        .o_op         (disp_op)
    );

    rs_switch #(
        .OPTN_RS_COUNT   (OPTN_RS_COUNT),
        .OPTN_CDB_DEPTH  (OPTN_CDB_DEPTH),
        .OPTN_RS_FU_MASK (OPTN_RS_FU_MASK)
    ) u_rs_switch (
        .clk          (clk),
        .i_arst_n     (i_arst_n),
        .i_valid      (disp_valid),
        .i_op         (disp_op),
        .i_cdb        (i_cdb),
        .i_rs_full    (rs_full),
        .o_reserve_en (rs_reserve_en),
        .o_op         (rs_op),
        .o_stall      (switch_stall)
    );

    for (genvar g = 0; g < OPTN_RS_COUNT; g++) begin : g_station
        rs_station #(
            .OPTN_RS_DEPTH  (OPTN_RS_DEPTH),
            .OPTN_CDB_DEPTH (OPTN_CDB_DEPTH)
        ) u_rs_station (
            .clk           (clk),
            .i_arst_n      (i_arst_n),
            .i_reserve_en  (rs_reserve_en[g]),
            .i_op          (rs_op),
            .i_cdb         (i_cdb),
            .o_full        (rs_full[g]),
            .o_issue_valid (o_issue_valid[g]),
            .o_issue       (o_issue[g]),
            .i_issue_ready (i_issue_ready[g])
        );
    end

endmodule

/* verif/rs_tb.sv */
// Testbench that plays front end, CDB and functional units around rs_dispatch_top
// Pending source tags in the table are unique, and CDB port s carries source s
// Needs OPTN_CDB_DEPTH >= SRC_COUNT for same-cycle bypass of both sources
`timescale 1ns/10ps

module rs_tb
    import rs_pkg::*;
();

    localparam int                  RS_COUNT       = 3;
    localparam int                  RS_DEPTH       = 4;
    localparam int                  CDB_DEPTH      = 2;
    localparam logic [RS_COUNT-1:0] FU_MASK        = 3'b100;
    localparam int                  NUM_STIM       = 23;
    localparam int                  NUM_TESTS      = 5;
    localparam int                  TIMEOUT_CYCLES = NUM_STIM * (RS_DEPTH + 20);
    localparam int                  CDB_NONE       = 0;
    localparam int                  CDB_BYPASS     = 1;
    localparam int                  CDB_LATE       = 2;
    localparam int                  CDB_DECOY      = 3;

    typedef struct packed {
        int     test;
        rs_op_e op;
        int     dst;
        int     rdy0;
        int     tag0;
        int     rdy1;
        int     tag1;
        int     cdb_mode;
        int     ordered;
    } stim_t;

    logic                clk;
    logic                i_arst_n;
    logic                i_disp_valid;
    rs_op_t              i_disp_op;
    logic                o_disp_stall;
    rs_cdb_t             cdb [0:CDB_DEPTH-1];
    logic [RS_COUNT-1:0] o_issue_valid;
    rs_issue_t           o_issue [0:RS_COUNT-1];
    logic [RS_COUNT-1:0] i_issue_ready;

    stim_t       stim [0:NUM_STIM-1];
    rs_issue_t   exp_issue [0:NUM_STIM-1];
    int          tag_to_idx [0:(1<<TAG_WIDTH)-1];
    logic        issued [0:NUM_STIM-1];
    int          issued_station [0:NUM_STIM-1];
    int          last_ordered [0:RS_COUNT-1];
    logic [31:0] bcast_done;
    logic [31:0] lfsr;
    logic        hold_ready;
    logic        stall_seen;
    int          issued_total;
    int          error_count;
    int          cycle_count = 0;

    rs_dispatch_top #(
        .OPTN_RS_COUNT   (RS_COUNT),
        .OPTN_RS_DEPTH   (RS_DEPTH),
        .OPTN_CDB_DEPTH  (CDB_DEPTH),
        .OPTN_RS_FU_MASK (FU_MASK)
    ) u_rs_dispatch_top (
        .clk           (clk),
        .i_arst_n      (i_arst_n),
        .i_disp_valid  (i_disp_valid),
        .i_disp_op     (i_disp_op),
        .o_disp_stall  (o_disp_stall),
        .i_cdb         (cdb),
        .o_issue_valid (o_issue_valid),
        .o_issue       (o_issue),
        .i_issue_ready (i_issue_ready)
    );

    always #20 clk = ~clk;

    // Fibonacci LFSR with taps 32, 22, 2 and 1
    function automatic logic take_bit();
        logic fb;
        fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic logic [DATA_WIDTH-1:0] rand_word();
        logic [DATA_WIDTH-1:0] w;
        w = '0;
        for (int i = 0; i < DATA_WIDTH; i++) begin
            w = {w[DATA_WIDTH-2:0], take_bit()};
        end
        return w;
    endfunction

    // Integer ops run on the IEU, memory ops on the LSU
    function automatic rs_fu_e fu_for_op(rs_op_e op);
        rs_fu_e fu;
        case (op)
            RS_OP_ALU:    fu = RS_FU_IEU;
            RS_OP_BRANCH: fu = RS_FU_IEU;
            RS_OP_LOAD:   fu = RS_FU_LSU;
            RS_OP_STORE:  fu = RS_FU_LSU;
        endcase
        return fu;
    endfunction

    function automatic logic src_ready(int k, int s);
        return (s == 0) ? (stim[k].rdy0 != 0) : (stim[k].rdy1 != 0);
    endfunction

    function automatic int src_tag(int k, int s);
        return (s == 0) ? stim[k].tag0 : stim[k].tag1;
    endfunction

    // Columns are test, op, dst tag, src0 rdy and tag, src1 rdy and tag, CDB mode, ordered
    task automatic fill_table();
        stim[0]  = '{1, RS_OP_ALU,    1,  1, 0,  1, 0,  CDB_NONE,   0};
        stim[1]  = '{1, RS_OP_BRANCH, 2,  1, 0,  1, 0,  CDB_NONE,   0};
        stim[2]  = '{1, RS_OP_ALU,    3,  1, 0,  1, 0,  CDB_NONE,   0};
        stim[3]  = '{1, RS_OP_LOAD,   4,  1, 0,  1, 0,  CDB_NONE,   0};
        stim[4]  = '{1, RS_OP_STORE,  5,  1, 0,  1, 0,  CDB_NONE,   0};
        stim[5]  = '{1, RS_OP_BRANCH, 6,  1, 0,  1, 0,  CDB_NONE,   0};
        stim[6]  = '{1, RS_OP_ALU,    7,  1, 0,  1, 0,  CDB_NONE,   0};
        stim[7]  = '{1, RS_OP_LOAD,   8,  1, 0,  1, 0,  CDB_NONE,   0};
        stim[8]  = '{2, RS_OP_ALU,    9,  1, 3,  1, 7,  CDB_DECOY,  0};
        stim[9]  = '{2, RS_OP_STORE,  10, 1, 5,  1, 9,  CDB_DECOY,  0};
        stim[10] = '{2, RS_OP_BRANCH, 11, 1, 1,  1, 2,  CDB_DECOY,  0};
        stim[11] = '{3, RS_OP_ALU,    12, 0, 20, 1, 0,  CDB_BYPASS, 0};
        stim[12] = '{3, RS_OP_LOAD,   13, 1, 0,  0, 21, CDB_BYPASS, 0};
        stim[13] = '{3, RS_OP_BRANCH, 14, 0, 22, 0, 23, CDB_BYPASS, 0};
        stim[14] = '{4, RS_OP_ALU,    15, 0, 24, 1, 0,  CDB_LATE,   0};
        stim[15] = '{4, RS_OP_STORE,  16, 0, 25, 0, 26, CDB_LATE,   0};
        stim[16] = '{4, RS_OP_BRANCH, 17, 0, 27, 0, 28, CDB_LATE,   0};
        // Only the ops that fill the empty station keep a fixed issue order
        stim[17] = '{5, RS_OP_LOAD,   18, 1, 0,  1, 0,  CDB_NONE,   1};
        stim[18] = '{5, RS_OP_STORE,  19, 1, 0,  1, 0,  CDB_NONE,   1};
        stim[19] = '{5, RS_OP_LOAD,   20, 1, 0,  1, 0,  CDB_NONE,   1};
        stim[20] = '{5, RS_OP_STORE,  21, 1, 0,  1, 0,  CDB_NONE,   1};
        stim[21] = '{5, RS_OP_LOAD,   22, 1, 0,  1, 0,  CDB_NONE,   0};
        stim[22] = '{5, RS_OP_STORE,  23, 1, 0,  1, 0,  CDB_NONE,   0};
    endtask

    task automatic check_issue(int k, rs_issue_t got);
        if (got !== exp_issue[k]) begin
            $display("FAIL %0t: tag %0d issued %h, expected %h",
                     $time, stim[k].dst, got, exp_issue[k]);
            error_count++;
        end
    endtask

    task automatic check_route(int k, int station);
        rs_fu_e got_fu;
        rs_fu_e exp_fu;
        got_fu = FU_MASK[station] ? RS_FU_LSU : RS_FU_IEU;
        exp_fu = fu_for_op(stim[k].op);
        if (got_fu !== exp_fu) begin
            $display("FAIL %0t: tag %0d issued from station %0d of type %s, expected %s",
                     $time, stim[k].dst, station, got_fu.name(), exp_fu.name());
            error_count++;
        end
    endtask

    task automatic record_issue(int station, rs_issue_t got);
        int k;
        k = tag_to_idx[got.dst_tag];
        if (k < 0) begin
            $display("FAIL %0t: station %0d issued unknown tag %0d", $time, station,
                     got.dst_tag);
            error_count++;
        end else if (issued[k]) begin
            $display("Op with tag %0d issued a second time at %0t", stim[k].dst, $time);
            error_count++;
        end else begin
            check_route(k, station);
            check_issue(k, got);
            for (int s = 0; s < SRC_COUNT; s++) begin
                if (stim[k].cdb_mode == CDB_LATE && !src_ready(k, s) &&
                    !bcast_done[src_tag(k, s)]) begin
                    $display("Op with tag %0d issued at %0t before tag %0d was broadcast",
                             stim[k].dst, $time, src_tag(k, s));
                    error_count++;
                end
            end
            if (stim[k].ordered != 0) begin
                if (k < last_ordered[station]) begin
                    $display("Op with tag %0d issued out of enqueue order at %0t",
                             stim[k].dst, $time);
                    error_count++;
                end
                last_ordered[station] = k;
            end
            issued[k]         = 1'b1;
            issued_station[k] = station;
            issued_total++;
        end
    endtask

    task automatic send_op(int k);
        rs_op_t                op;
        logic                  stalled;
        logic [DATA_WIDTH-1:0] data;
        op.op      = stim[k].op;
        op.dst_tag = TAG_WIDTH'(stim[k].dst);
        for (int s = 0; s < SRC_COUNT; s++) begin
            op.src[s].rdy  = src_ready(k, s);
            op.src[s].tag  = TAG_WIDTH'(src_tag(k, s));
            op.src[s].data = rand_word();
            exp_issue[k].src_data[s] = op.src[s].data;
        end
        exp_issue[k].op      = op.op;
        exp_issue[k].dst_tag = op.dst_tag;
        tag_to_idx[stim[k].dst] = k;
        @(posedge clk);
        i_disp_valid <= 1'b1;
        i_disp_op    <= op;
        // The op is taken on the first edge with the stall low
        stalled = 1'b1;
        while (stalled) begin
            @(negedge clk);
            stalled = o_disp_stall;
            @(posedge clk);
        end
        i_disp_valid <= 1'b0;
        if (stim[k].cdb_mode == CDB_BYPASS) begin
            // The op is in the dispatch register during this cycle
            for (int s = 0; s < SRC_COUNT; s++) begin
                if (!src_ready(k, s)) begin
                    data = rand_word();
                    exp_issue[k].src_data[s] = data;
                    cdb[s] <= '{1'b1, TAG_WIDTH'(src_tag(k, s)), data};
                end
            end
            @(posedge clk);
            for (int s = 0; s < SRC_COUNT; s++) begin
                cdb[s] <= '0;
                if (!src_ready(k, s)) begin
                    bcast_done[src_tag(k, s)] <= 1'b1;
                end
            end
        end else if (stim[k].cdb_mode == CDB_DECOY) begin
            // Results for tags the op already holds arrive in the switch and then the
            // station, and must leave the dispatched data alone
            for (int s = 0; s < SRC_COUNT; s++) begin
                cdb[s] <= '{1'b1, TAG_WIDTH'(src_tag(k, s)), ~exp_issue[k].src_data[s]};
            end
            repeat (2) @(posedge clk);
            for (int s = 0; s < SRC_COUNT; s++) begin
                cdb[s] <= '0;
            end
        end
    endtask

    task automatic send_ops(int first, int last);
        for (int k = first; k <= last; k++) begin
            send_op(k);
        end
    endtask

    // One tag per broadcast with idle cycles between, so each op waits on its last tag
    task automatic broadcast_late(int first, int last);
        logic [DATA_WIDTH-1:0] data;
        for (int k = first; k <= last; k++) begin
            for (int s = 0; s < SRC_COUNT; s++) begin
                if (stim[k].cdb_mode == CDB_LATE && !src_ready(k, s)) begin
                    data = rand_word();
                    exp_issue[k].src_data[s] = data;
                    @(posedge clk);
                    cdb[0] <= '{1'b1, TAG_WIDTH'(src_tag(k, s)), data};
                    @(posedge clk);
                    cdb[0] <= '0;
                    bcast_done[src_tag(k, s)] <= 1'b1;
                    repeat (2) @(posedge clk);
                end
            end
        end
    endtask

    task automatic check_alternation(int first, int last);
        for (int k = first + 1; k <= last; k++) begin
            if (fu_for_op(stim[k-1].op) == RS_FU_IEU && fu_for_op(stim[k].op) == RS_FU_IEU &&
                issued_station[k] == issued_station[k-1]) begin
                $display("FAIL %0t: IEU tags %0d and %0d both went to station %0d",
                         $time, stim[k-1].dst, stim[k].dst, issued_station[k]);
                error_count++;
            end
        end
    endtask

    always @(posedge clk) begin
        for (int s = 0; s < RS_COUNT; s++) begin
            i_issue_ready[s] <= hold_ready ? 1'b0 : take_bit();
        end
    end

    // Functional unit model, an op is taken where valid and ready are both high
    always @(negedge clk) begin
        if (i_arst_n) begin
            if (o_disp_stall) begin
                stall_seen = 1'b1;
            end
            for (int s = 0; s < RS_COUNT; s++) begin
                if (o_issue_valid[s] && i_issue_ready[s]) begin
                    record_issue(s, o_issue[s]);
                end
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > TIMEOUT_CYCLES) begin
            $display("Timeout, the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Verification failed");
            $finish;
        end
    end

    initial begin
        int first;
        int last;
        int test_errors;
        int failed_tests;
        clk           = 1'b0;
        i_arst_n      = 1'b0;
        i_disp_valid  = 1'b0;
        i_disp_op     = '0;
        i_issue_ready = '0;
        for (int c = 0; c < CDB_DEPTH; c++) begin
            cdb[c] = '0;
        end
        lfsr         = 32'hfa3f;
        hold_ready   = 1'b0;
        stall_seen   = 1'b0;
        bcast_done   = '0;
        issued_total = 0;
        error_count  = 0;
        failed_tests = 0;
        for (int i = 0; i < (1 << TAG_WIDTH); i++) begin
            tag_to_idx[i] = -1;
        end
        for (int k = 0; k < NUM_STIM; k++) begin
            issued[k]         = 1'b0;
            issued_station[k] = -1;
        end
        for (int s = 0; s < RS_COUNT; s++) begin
            last_ordered[s] = -1;
        end
        fill_table();
        repeat (2) @(posedge clk);
        i_arst_n <= 1'b1;
        @(negedge clk);
        if (o_issue_valid != '0 || o_disp_stall) begin
            $display("FAIL %0t: outputs were not idle after reset", $time);
            error_count++;
        end
        first = 0;
        for (int t = 1; t <= NUM_TESTS; t++) begin
            test_errors = error_count;
            last = first;
            while (last + 1 < NUM_STIM && stim[last + 1].test == t) begin
                last++;
            end
            if (t == 5) begin
                // Hold the functional units off until the full station stalls dispatch
                @(posedge clk);
                hold_ready <= 1'b1;
                stall_seen = 1'b0;
                fork
                    send_ops(first, last);
                    begin
                        wait (stall_seen);
                        repeat (4) @(posedge clk);
                        hold_ready <= 1'b0;
                    end
                join
            end else begin
                send_ops(first, last);
            end
            if (t == 4) begin
                broadcast_late(first, last);
            end
            wait (issued_total == last + 1);
            if (t == 1) begin
                check_alternation(first, last);
            end
            test_errors = error_count - test_errors;
            if (test_errors != 0) begin
                failed_tests++;
            end
            $display("Test %0d finished at %0t with %0d errors", t, $time, test_errors);
            first = last + 1;
        end
        // Idle cycles catch any op that issues a second time
        repeat (10) @(posedge clk);
        $display("Summary: %0d tests, %0d with errors, %0d errors, %0d ops issued",
                 NUM_TESTS, failed_tests, error_count, issued_total);
        if (error_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

/* build.f */
hw/rs_pkg.sv
hw/rs_rr_picker.sv
hw/rs_dispatch_stage.sv
hw/rs_switch.sv
hw/rs_station.sv
hw/rs_dispatch_top.sv
verif/rs_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -sv
TOP       = rs_tb
FILELIST  = build.f
OBJ_DIR   = obj_dir
PASS_MSG  = Verification passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
